//--- mem_iq_pkg.sv
/*
 * Memory issue queue package
 * Queue sizes, micro-op field widths and the second-register union
 */
package mem_iq_pkg;

  // Queue geometry
  localparam int IQ_SIZE         = 8;
  localparam int DISPATCH_WIDTH  = 2;
  localparam int SLOT_INDEX_BITS = 3;
  localparam int COUNT_BITS      = 4;

  // Micro-op fields
  localparam int PRF_INDEX_BITS  = 6;
  localparam int IMM_BITS        = 12;
  localparam int LSQ_TAG_BITS    = 4;

  // Second register field of a memory micro-op
  // A load names its destination here, a store its data source
  typedef union packed {
    logic [PRF_INDEX_BITS-1:0] dest_index;
    logic [PRF_INDEX_BITS-1:0] data_index;
  } mem_reg2_t;

endpackage

//--- mem_issue_slot.sv
/*
 * Memory issue slot
 * Holds one load or store micro-op, loads from dispatch or shifts down
 * from the slot above, and reports when its sources are ready
 */
`timescale 1ns/10ps

module mem_issue_slot import mem_iq_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      load,
  input  logic                      shift,

  input  logic                      in_is_store,
  input  logic [PRF_INDEX_BITS-1:0] in_rs1_index,
  input  mem_reg2_t                 in_reg2,
  input  logic [IMM_BITS-1:0]       in_imm,
  input  logic [LSQ_TAG_BITS-1:0]   in_tag,

  input  logic                      next_occupied,
  input  logic                      next_is_store,
  input  logic [PRF_INDEX_BITS-1:0] next_rs1_index,
  input  mem_reg2_t                 next_reg2,
  input  logic [IMM_BITS-1:0]       next_imm,
  input  logic [LSQ_TAG_BITS-1:0]   next_tag,

  output logic                      occupied,
  output logic                      is_store,
  output logic [PRF_INDEX_BITS-1:0] rs1_index,
  output mem_reg2_t                 reg2,
  output logic [IMM_BITS-1:0]       imm,
  output logic [LSQ_TAG_BITS-1:0]   tag,

  input  logic                      rs1_busy,
  input  logic                      rs2_busy,
  output logic [PRF_INDEX_BITS-1:0] rs2_index,
  output logic                      ready
);

  always_ff @(posedge clock) begin
    if (reset) begin
      occupied <= 1'b0;
      is_store <= 1'b0;
    end else if (load) begin
      occupied <= 1'b1;
      is_store <= in_is_store;
    end else if (shift) begin
      occupied <= next_occupied;
      is_store <= next_is_store;
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      rs1_index <= in_rs1_index;
      reg2      <= in_reg2;
      imm       <= in_imm;
      tag       <= in_tag;
    end else if (shift) begin
      rs1_index <= next_rs1_index;
      reg2      <= next_reg2;
      imm       <= next_imm;
      tag       <= next_tag;
    end
  end

  // Only a store waits on its second register
  assign rs2_index = is_store ? reg2.data_index : '0;
  assign ready     = occupied & ~rs1_busy & (~is_store | ~rs2_busy);

endmodule

//--- mem_iq_allocator.sv
/*
 * Memory issue queue allocator
 * Tracks tail and free count, steers dispatched micro-ops into free
 * slots and raises full when a dispatch pair may no longer fit
 */
`timescale 1ns/10ps

module mem_iq_allocator import mem_iq_pkg::*; (
  input  logic                                          clock,
  input  logic                                          reset,

  input  logic      [DISPATCH_WIDTH-1:0]                in_valid,
  input  logic      [DISPATCH_WIDTH-1:0]                in_is_store,
  input  logic      [DISPATCH_WIDTH-1:0][PRF_INDEX_BITS-1:0] in_rs1_index,
  input  mem_reg2_t [DISPATCH_WIDTH-1:0]                in_reg2,
  input  logic      [DISPATCH_WIDTH-1:0][IMM_BITS-1:0]  in_imm,
  input  logic      [DISPATCH_WIDTH-1:0][LSQ_TAG_BITS-1:0] in_tag,

  input  logic                                          issue_fire,

  output logic      [IQ_SIZE-1:0]                       load,
  output logic      [IQ_SIZE-1:0]                       slot_is_store,
  output logic      [IQ_SIZE-1:0][PRF_INDEX_BITS-1:0]   slot_rs1_index,
  output mem_reg2_t [IQ_SIZE-1:0]                       slot_reg2,
  output logic      [IQ_SIZE-1:0][IMM_BITS-1:0]         slot_imm,
  output logic      [IQ_SIZE-1:0][LSQ_TAG_BITS-1:0]     slot_tag,

  output logic                                          full
);

  logic [COUNT_BITS-1:0] tail;
  logic [COUNT_BITS-1:0] free_count;
  logic [COUNT_BITS-1:0] in_count;
  logic [COUNT_BITS-1:0] out_count;
  logic [COUNT_BITS-1:0] base;
  logic [COUNT_BITS-1:0] pos;

  assign out_count = {{(COUNT_BITS-1){1'b0}}, issue_fire};

  // The issued slot compacts away this cycle, so writes land one lower
  assign base = tail - out_count;

  always_comb begin
    load           = '0;
    slot_is_store  = '0;
    slot_rs1_index = '0;
    slot_reg2      = '0;
    slot_imm       = '0;
    slot_tag       = '0;
    in_count       = '0;
    pos            = '0;
    for (int i = 0; i < DISPATCH_WIDTH; i++) begin
      if (in_valid[i]) begin
        // Rank among valid lanes keeps gaps out of the queue
        pos = base + in_count;
        if (pos < COUNT_BITS'(IQ_SIZE)) begin
          load[pos[SLOT_INDEX_BITS-1:0]]           = 1'b1;
          slot_is_store[pos[SLOT_INDEX_BITS-1:0]]  = in_is_store[i];
          slot_rs1_index[pos[SLOT_INDEX_BITS-1:0]] = in_rs1_index[i];
          slot_reg2[pos[SLOT_INDEX_BITS-1:0]]      = in_reg2[i];
          slot_imm[pos[SLOT_INDEX_BITS-1:0]]       = in_imm[i];
          slot_tag[pos[SLOT_INDEX_BITS-1:0]]       = in_tag[i];
        end
        in_count = in_count + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      tail       <= '0;
      free_count <= COUNT_BITS'(IQ_SIZE);
    end else begin
      tail       <= tail + in_count - out_count;
      free_count <= free_count - in_count + out_count;
    end
  end

  assign full = free_count < COUNT_BITS'(DISPATCH_WIDTH);

endmodule

//--- mem_iq_selector.sv
/*
 * Memory issue queue selector
 * Picks the oldest eligible slot, holds stores until they reach slot 0,
 * stalls on ex_busy and builds the compaction shift mask
 */
`timescale 1ns/10ps

module mem_iq_selector import mem_iq_pkg::*; (
  input  logic [IQ_SIZE-1:0]         ready,
  input  logic [IQ_SIZE-1:0]         occupied,
  input  logic [IQ_SIZE-1:0]         is_store,
  input  logic                       ex_busy,

  output logic [SLOT_INDEX_BITS-1:0] issue_sel,
  output logic                       issue_fire,
  output logic [IQ_SIZE-1:0]         shift
);

  logic [IQ_SIZE-1:0] eligible;
  logic               found;

  // A store may only leave from the oldest slot
  always_comb begin
    for (int k = 0; k < IQ_SIZE; k++) begin
      eligible[k] = occupied[k] & ready[k] & (~is_store[k] | (k == 0));
    end
  end

  // Lowest slot number is the oldest entry
  always_comb begin
    issue_sel = '0;
    found     = 1'b0;
    for (int k = IQ_SIZE - 1; k >= 0; k--) begin
      if (eligible[k]) begin
        issue_sel = SLOT_INDEX_BITS'(k);
        found     = 1'b1;
      end
    end
  end

  assign issue_fire = found & ~ex_busy;

  // Everything at or above the issued slot moves down one
  always_comb begin
    for (int k = 0; k < IQ_SIZE; k++) begin
      shift[k] = issue_fire & (SLOT_INDEX_BITS'(k) >= issue_sel);
    end
  end

endmodule

//--- mem_issue_queue.sv
/*
 * Memory issue queue
 * Eight-entry compacting queue for load and store micro-ops, two in
 * per cycle from dispatch and one out per cycle to the memory pipe
 */
`timescale 1ns/10ps

module mem_issue_queue import mem_iq_pkg::*; (
  input  logic                                          clock,
  input  logic                                          reset,

  input  logic      [DISPATCH_WIDTH-1:0]                in_valid,
  input  logic      [DISPATCH_WIDTH-1:0]                in_is_store,
  input  logic      [DISPATCH_WIDTH-1:0][PRF_INDEX_BITS-1:0] in_rs1_index,
  input  mem_reg2_t [DISPATCH_WIDTH-1:0]                in_reg2,
  input  logic      [DISPATCH_WIDTH-1:0][IMM_BITS-1:0]  in_imm,
  input  logic      [DISPATCH_WIDTH-1:0][LSQ_TAG_BITS-1:0] in_tag,
  output logic                                          full,

  output logic      [IQ_SIZE-1:0][PRF_INDEX_BITS-1:0]   slot_rs1_index,
  output logic      [IQ_SIZE-1:0][PRF_INDEX_BITS-1:0]   slot_rs2_index,
  input  logic      [IQ_SIZE-1:0]                       rs1_busy,
  input  logic      [IQ_SIZE-1:0]                       rs2_busy,

  input  logic                                          ex_busy,
  output logic                                          issue_valid,
  output logic                                          issue_is_store,
  output logic      [PRF_INDEX_BITS-1:0]                issue_rs1_index,
  output mem_reg2_t                                     issue_reg2,
  output logic      [IMM_BITS-1:0]                      issue_imm,
  output logic      [LSQ_TAG_BITS-1:0]                  issue_tag
);

  logic      [IQ_SIZE-1:0]                     load;
  logic      [IQ_SIZE-1:0]                     shift;
  logic      [IQ_SIZE-1:0]                     ready;
  logic      [IQ_SIZE-1:0]                     alloc_is_store;
  logic      [IQ_SIZE-1:0][PRF_INDEX_BITS-1:0] alloc_rs1_index;
  mem_reg2_t [IQ_SIZE-1:0]                     alloc_reg2;
  logic      [IQ_SIZE-1:0][IMM_BITS-1:0]       alloc_imm;
  logic      [IQ_SIZE-1:0][LSQ_TAG_BITS-1:0]   alloc_tag;

  // Slot state, with one extra always-empty entry above the top slot
  logic      [IQ_SIZE:0]                       q_occupied;
  logic      [IQ_SIZE:0]                       q_is_store;
  logic      [IQ_SIZE:0][PRF_INDEX_BITS-1:0]   q_rs1_index;
  mem_reg2_t [IQ_SIZE:0]                       q_reg2;
  logic      [IQ_SIZE:0][IMM_BITS-1:0]         q_imm;
  logic      [IQ_SIZE:0][LSQ_TAG_BITS-1:0]     q_tag;

  logic      [SLOT_INDEX_BITS-1:0]             issue_sel;
  logic                                        issue_fire;

  mem_iq_allocator i_allocator (
    .clock          (clock),
    .reset          (reset),
    .in_valid       (in_valid),
    .in_is_store    (in_is_store),
    .in_rs1_index   (in_rs1_index),
    .in_reg2        (in_reg2),
    .in_imm         (in_imm),
    .in_tag         (in_tag),
    .issue_fire     (issue_fire),
    .load           (load),
    .slot_is_store  (alloc_is_store),
    .slot_rs1_index (alloc_rs1_index),
    .slot_reg2      (alloc_reg2),
    .slot_imm       (alloc_imm),
    .slot_tag       (alloc_tag),
    .full           (full)
  );

  assign q_occupied[IQ_SIZE]  = 1'b0;
  assign q_is_store[IQ_SIZE]  = 1'b0;
  assign q_rs1_index[IQ_SIZE] = '0;
  assign q_reg2[IQ_SIZE]      = '0;
  assign q_imm[IQ_SIZE]       = '0;
  assign q_tag[IQ_SIZE]       = '0;

  for (genvar k = 0; k < IQ_SIZE; k++) begin : g_slot
    mem_issue_slot i_slot (
      .clock          (clock),
      .reset          (reset),
      .load           (load[k]),
      .shift          (shift[k]),
      .in_is_store    (alloc_is_store[k]),
      .in_rs1_index   (alloc_rs1_index[k]),
      .in_reg2        (alloc_reg2[k]),
      .in_imm         (alloc_imm[k]),
      .in_tag         (alloc_tag[k]),
      .next_occupied  (q_occupied[k+1]),
      .next_is_store  (q_is_store[k+1]),
      .next_rs1_index (q_rs1_index[k+1]),
      .next_reg2      (q_reg2[k+1]),
      .next_imm       (q_imm[k+1]),
      .next_tag       (q_tag[k+1]),
      .occupied       (q_occupied[k]),
      .is_store       (q_is_store[k]),
      .rs1_index      (q_rs1_index[k]),
      .reg2           (q_reg2[k]),
      .imm            (q_imm[k]),
      .tag            (q_tag[k]),
      .rs1_busy       (rs1_busy[k]),
      .rs2_busy       (rs2_busy[k]),
      .rs2_index      (slot_rs2_index[k]),
      .ready          (ready[k])
    );
  end

  assign slot_rs1_index = q_rs1_index[IQ_SIZE-1:0];

  mem_iq_selector i_selector (
    .ready      (ready),
    .occupied   (q_occupied[IQ_SIZE-1:0]),
    .is_store   (q_is_store[IQ_SIZE-1:0]),
    .ex_busy    (ex_busy),
    .issue_sel  (issue_sel),
    .issue_fire (issue_fire),
    .shift      (shift)
  );

  // Issue output mux
  assign issue_valid     = issue_fire;
  assign issue_is_store  = q_is_store[issue_sel];
  assign issue_rs1_index = q_rs1_index[issue_sel];
  assign issue_reg2      = q_reg2[issue_sel];
  assign issue_imm       = q_imm[issue_sel];
  assign issue_tag       = q_tag[issue_sel];

endmodule

//--- mem_iq_tests.svh
/*
 * Directed tests for the memory issue queue
 * Each test starts and ends just after a rising clock edge
 */

task automatic test_reset_state;
  test_name = "reset_state";
  @(negedge clock);
  check_value("issue_valid", 0, issue_valid);
  check_value("full", 0, full);
  @(posedge clock);
  define_uop(4'd1, 1'b0, 6'd5, 6'd9);
  dispatch_pair(1'b1, 4'd1, 1'b0, 4'd0);
  // Operands free, so issue follows in the very next cycle
  expect_issue(4'd1, 1'b0, 0);
endtask

task automatic test_oldest_ready;
  test_name = "oldest_ready";
  ex_busy      <= 1'b1;
  prf_busy[10] <= 1'b1;
  define_uop(4'd2, 1'b0, 6'd10, 6'd31);
  define_uop(4'd3, 1'b0, 6'd11, 6'd32);
  define_uop(4'd4, 1'b0, 6'd12, 6'd33);
  dispatch_pair(1'b1, 4'd2, 1'b1, 4'd3);
  dispatch_pair(1'b1, 4'd4, 1'b0, 4'd0);
  ex_busy <= 1'b0;
  expect_issue(4'd3, 1'b0, 1);
  expect_issue(4'd4, 1'b0, 1);
  expect_idle(4);
  prf_busy[10] <= 1'b0;
  expect_issue(4'd2, 1'b0, 1);
endtask

task automatic test_store_ordering;
  test_name = "store_ordering";
  // Ready store held behind a waiting load
  prf_busy[20] <= 1'b1;
  define_uop(4'd5, 1'b0, 6'd20, 6'd36);
  define_uop(4'd6, 1'b1, 6'd21, 6'd22);
  dispatch_pair(1'b1, 4'd5, 1'b1, 4'd6);
  // A load presents no data register to the busy table
  @(negedge clock);
  check_value("slot_rs1_index[0]", uop_rs1[5], slot_rs1_index[0]);
  check_value("slot_rs2_index[0]", 0, slot_rs2_index[0]);
  check_value("slot_rs1_index[1]", uop_rs1[6], slot_rs1_index[1]);
  check_value("slot_rs2_index[1]", uop_reg2[6], slot_rs2_index[1]);
  @(posedge clock);
  expect_idle(4);
  prf_busy[20] <= 1'b0;
  expect_issue(4'd5, 1'b0, 1);
  expect_issue(4'd6, 1'b1, 0);
  // Store data register busy
  prf_busy[23] <= 1'b1;
  define_uop(4'd7, 1'b1, 6'd21, 6'd23);
  dispatch_pair(1'b1, 4'd7, 1'b0, 4'd0);
  expect_idle(4);
  prf_busy[23] <= 1'b0;
  expect_issue(4'd7, 1'b1, 1);
  // A load never waits on its destination
  prf_busy[24] <= 1'b1;
  define_uop(4'd8, 1'b0, 6'd21, 6'd24);
  dispatch_pair(1'b1, 4'd8, 1'b0, 4'd0);
  expect_issue(4'd8, 1'b0, 0);
  prf_busy[24] <= 1'b0;
endtask

task automatic test_back_pressure;
  test_name = "back_pressure";
  ex_busy <= 1'b1;
  define_uop(4'd9, 1'b0, 6'd13, 6'd34);
  define_uop(4'd10, 1'b1, 6'd14, 6'd15);
  define_uop(4'd11, 1'b0, 6'd16, 6'd35);
  dispatch_pair(1'b1, 4'd9, 1'b1, 4'd10);
  dispatch_pair(1'b1, 4'd11, 1'b0, 4'd0);
  expect_idle(10);
  ex_busy <= 1'b0;
  expect_issue(4'd9, 1'b0, 1);
  expect_issue(4'd10, 1'b1, 1);
  expect_issue(4'd11, 1'b0, 1);
  expect_idle(2);
endtask

task automatic test_capacity;
  test_name = "capacity";
  ex_busy <= 1'b1;
  for (int t = 0; t < IQ_SIZE; t++) begin
    define_uop(LSQ_TAG_BITS'(t), (t == 2) || (t == 5), PRF_INDEX_BITS'(40 + t),
               PRF_INDEX_BITS'(50 + t));
  end
  dispatch_pair(1'b1, 4'd0, 1'b1, 4'd1);
  dispatch_pair(1'b1, 4'd2, 1'b1, 4'd3);
  dispatch_pair(1'b1, 4'd4, 1'b1, 4'd5);
  // Two slots still free, enough for one more pair
  expect_full(1'b0, 1);
  dispatch_pair(1'b1, 4'd6, 1'b1, 4'd7);
  expect_full(1'b1, 4);
  ex_busy <= 1'b0;
  for (int t = 0; t < IQ_SIZE; t++) begin
    expect_issue(LSQ_TAG_BITS'(t), uop_store[t], 1);
  end
  expect_idle(2);
  expect_full(1'b0, 1);
endtask

//--- mem_iq_tb.sv
/*
 * Memory issue queue testbench
 * Models the busy table and drives directed dispatch and issue tests
 */
`timescale 1ns/10ps

module mem_iq_tb import mem_iq_pkg::*; ();

  logic                                               clock;
  logic                                               reset;
  logic      [DISPATCH_WIDTH-1:0]                     in_valid;
  logic      [DISPATCH_WIDTH-1:0]                     in_is_store;
  logic      [DISPATCH_WIDTH-1:0][PRF_INDEX_BITS-1:0] in_rs1_index;
  mem_reg2_t [DISPATCH_WIDTH-1:0]                     in_reg2;
  logic      [DISPATCH_WIDTH-1:0][IMM_BITS-1:0]       in_imm;
  logic      [DISPATCH_WIDTH-1:0][LSQ_TAG_BITS-1:0]   in_tag;
  logic                                               full;
  logic      [IQ_SIZE-1:0][PRF_INDEX_BITS-1:0]        slot_rs1_index;
  logic      [IQ_SIZE-1:0][PRF_INDEX_BITS-1:0]        slot_rs2_index;
  logic      [IQ_SIZE-1:0]                            rs1_busy;
  logic      [IQ_SIZE-1:0]                            rs2_busy;
  logic                                               ex_busy;
  logic                                               issue_valid;
  logic                                               issue_is_store;
  logic      [PRF_INDEX_BITS-1:0]                     issue_rs1_index;
  mem_reg2_t                                          issue_reg2;
  logic      [IMM_BITS-1:0]                           issue_imm;
  logic      [LSQ_TAG_BITS-1:0]                       issue_tag;

  // Busy table model and the dispatched micro-ops, indexed by tag
  logic                      prf_busy [2**PRF_INDEX_BITS];
  logic                      uop_store [2**LSQ_TAG_BITS];
  logic [PRF_INDEX_BITS-1:0] uop_rs1 [2**LSQ_TAG_BITS];
  mem_reg2_t                 uop_reg2 [2**LSQ_TAG_BITS];
  logic [IMM_BITS-1:0]       uop_imm [2**LSQ_TAG_BITS];
  logic [31:0]               lcg_state;
  string                     test_name;

  mem_issue_queue i_dut (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  always_comb begin
    for (int k = 0; k < IQ_SIZE; k++) begin
      rs1_busy[k] = prf_busy[slot_rs1_index[k]];
      rs2_busy[k] = prf_busy[slot_rs2_index[k]];
    end
  end

  function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input string what, input int expected, input int actual);
    assert (actual == expected) else begin
      $display("CHECK FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("%s: timed out waiting for %s", test_name, what);
    $display("test failed");
    $fatal(1, "timeout");
  endtask

  task automatic define_uop(input logic [LSQ_TAG_BITS-1:0] tag, input logic is_store,
                            input logic [PRF_INDEX_BITS-1:0] rs1,
                            input logic [PRF_INDEX_BITS-1:0] reg2);
    logic [31:0] rnd;
    rnd = next_random();
    uop_store[tag] = is_store;
    uop_rs1[tag]   = rs1;
    uop_reg2[tag]  = reg2;
    uop_imm[tag] = rnd[IMM_BITS-1:0];
  endtask

  // Offers up to two micro-ops for one edge once full is low
  task automatic dispatch_pair(input logic valid0, input logic [LSQ_TAG_BITS-1:0] tag0,
                               input logic valid1, input logic [LSQ_TAG_BITS-1:0] tag1);
    int waited;
    waited = 0;
    @(negedge clock);
    while (full) begin
      assert (waited < 20) else report_timeout("full to fall before dispatch");
      @(negedge clock);
      waited++;
    end
    @(posedge clock);
    in_valid     <= {valid1, valid0};
    in_is_store  <= {uop_store[tag1], uop_store[tag0]};
    in_rs1_index <= {uop_rs1[tag1], uop_rs1[tag0]};
    in_reg2      <= {uop_reg2[tag1], uop_reg2[tag0]};
    in_imm       <= {uop_imm[tag1], uop_imm[tag0]};
    in_tag       <= {tag1, tag0};
    @(posedge clock);
    in_valid <= '0;
  endtask

  task automatic expect_issue(input logic [LSQ_TAG_BITS-1:0] tag, input logic is_store,
                              input int max_wait);
    int waited;
    waited = 0;
    @(negedge clock);
    while (!issue_valid) begin
      assert (waited < max_wait) else
        report_timeout($sformatf("issue_valid with tag %0d", tag));
      @(negedge clock);
      waited++;
    end
    check_value("issue_tag", tag, issue_tag);
    check_value("issue_is_store", is_store, issue_is_store);
    check_value("issue_rs1_index", uop_rs1[tag], issue_rs1_index);
    check_value("issue_reg2", uop_reg2[tag], issue_reg2);
    check_value("issue_imm", uop_imm[tag], issue_imm);
    @(posedge clock);
  endtask

  task automatic expect_idle(input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      check_value("issue_valid", 0, issue_valid);
    end
    @(posedge clock);
  endtask

  task automatic expect_full(input logic expected, input int cycles);
    repeat (cycles) begin
      @(negedge clock);
      check_value("full", expected, full);
    end
    @(posedge clock);
  endtask

  `include "mem_iq_tests.svh"

  initial begin
    lcg_state = 32'h5f86c53f;
    test_name = "reset";
    for (int r = 0; r < 2**PRF_INDEX_BITS; r++) begin
      prf_busy[r] <= 1'b0;
    end
    reset        <= 1'b1;
    in_valid     <= '0;
    in_is_store  <= '0;
    in_rs1_index <= '0;
    in_reg2      <= '0;
    in_imm       <= '0;
    in_tag       <= '0;
    ex_busy      <= 1'b0;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    test_reset_state();
    test_oldest_ready();
    test_store_ordering();
    test_back_pressure();
    test_capacity();
    $display("test passed");
    $finish;
  end

endmodule

//--- mem_iq.f
+incdir+.
mem_iq_pkg.sv
mem_issue_slot.sv
mem_iq_allocator.sv
mem_iq_selector.sv
mem_issue_queue.sv
mem_iq_tb.sv

//--- run_mem_iq.sh
#!/bin/sh
# Build and run the mem_iq testbench with Verilator, judge the run from its log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --assert -Wno-fatal -f mem_iq.f --top-module mem_iq_tb -o mem_iq_sim &&
./obj_dir/mem_iq_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
